/* ahb_os_pkg.sv */
// AHB output stage bus widths, transfer encodings and per-port payload types
package ahb_os_pkg;

  // ----------------------------------------
  // Bus widths
  // ----------------------------------------
  localparam int ADDR_W = 32;                     // HADDR width
  localparam int DATA_W = 32;                     // HWDATA width

  // ----------------------------------------
  // HTRANS and HBURST encodings
  // ----------------------------------------
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;   // No transfer
  localparam logic [1:0] HTRANS_BUSY   = 2'b01;   // Burst pause
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;   // First beat
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;   // Burst continuation

  localparam logic [2:0] HBURST_SINGLE = 3'b000;  // Single transfer

  // ----------------------------------------
  // Port payloads
  // ----------------------------------------
  // Address phase of one input port, also the shape of the slave side
  typedef struct packed {
    logic              sel;       // HSEL from the input stage
    logic [ADDR_W-1:0] addr;      // HADDR
    logic [1:0]        trans;     // HTRANS
    logic              write;     // HWRITE
    logic [2:0]        size;      // HSIZE
    logic [2:0]        burst;     // HBURST
    logic [3:0]        prot;      // HPROT
    logic              mastlock;  // HMASTLOCK
  } ahb_addr_t;

  // Write data of one input port
  typedef logic [DATA_W-1:0] ahb_wdata_t;

endpackage

/* ahb_os_arbiter.sv */
// Round-robin arbiter for the output stage with burst and locked-sequence hold
`timescale 1ns/1ps

module ahb_os_arbiter #(
  parameter  int NUM_PORTS = 4,                              // Input ports
  localparam int IDX_W     = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
  input  logic                 HCLK,          // AHB clock
  input  logic                 HRESETn,       // Sync reset, active low
  input  logic [NUM_PORTS-1:0] i_req,         // Held tran AND sel per port
  input  logic                 i_hready,      // HREADYMUXM feedback
  input  logic [1:0]           i_trans,       // HTRANS of granted port
  input  logic                 i_hlock,       // Lock qualified by hsel_lock
  output logic [IDX_W-1:0]     o_grant_idx,   // Address-phase port
  output logic                 o_no_port      // Nobody owns the slave
);

  // ----------------------------------------
  // State
  // ----------------------------------------
  logic [IDX_W-1:0] grant_q;                  // Current owner
  logic [IDX_W-1:0] last_q;                   // Round-robin base
  logic             no_port_q;                // No owner flag

  logic             burst_cont;               // SEQ or BUSY on the bus
  logic             hold;                     // Keep current owner
  logic             rr_found;                 // Some port requests
  logic [IDX_W-1:0] rr_idx;                   // Next port in circular order

  // Owner keeps the slave through a burst or a locked sequence
  assign burst_cont = (i_trans == ahb_os_pkg::HTRANS_SEQ) ||
                      (i_trans == ahb_os_pkg::HTRANS_BUSY);
  assign hold       = !no_port_q && (burst_cont || i_hlock);

  // ----------------------------------------
  // Round-robin search
  // ----------------------------------------
  always_comb
  begin
    int cand;                                 // Candidate port number

    rr_found = 1'b0;
    rr_idx   = last_q;                        // Unused unless found
    cand     = 0;
    for (int off = 1; off <= NUM_PORTS; off++)
    begin
      cand = (int'(last_q) + off) % NUM_PORTS;  // Start just after last winner
      if (!rr_found && i_req[cand])
      begin
        rr_found = 1'b1;
        rr_idx   = IDX_W'(cand);
      end
    end
  end

  // ----------------------------------------
  // Grant registers
  // ----------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      grant_q   <= '0;
      last_q    <= IDX_W'(NUM_PORTS - 1);     // Port 0 wins first
      no_port_q <= 1'b1;
    end
    else if (i_hready && !hold)               // Re-arbitrate on free edges
    begin
      if (rr_found)
      begin
        grant_q   <= rr_idx;
        last_q    <= rr_idx;
        no_port_q <= 1'b0;
      end
      else
      begin
        no_port_q <= 1'b1;                    // Grant index keeps value
      end
    end
  end

  assign o_grant_idx = grant_q;
  assign o_no_port   = no_port_q;

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  // Wait states freeze the address-phase owner
  a_grant_stable_wait : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    !i_hready |=> ($stable(o_grant_idx) && $stable(o_no_port))
  );

endmodule

/* ahb_os_addr_phase.sv */
// Address and control mux of the granted port with per-port active decode
`timescale 1ns/1ps

module ahb_os_addr_phase #(
  parameter  int NUM_PORTS = 4,                              // Input ports
  localparam int IDX_W     = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
  input  ahb_os_pkg::ahb_addr_t [NUM_PORTS-1:0] i_port_addr,  // All ports
  input  logic [IDX_W-1:0]                      i_grant_idx,  // Owner
  input  logic                                  i_no_port,    // No owner
  output ahb_os_pkg::ahb_addr_t                 o_sel_addr,   // To slave
  output logic [NUM_PORTS-1:0]                  o_active      // Owner flag
);

  // ----------------------------------------
  // Address phase mux
  // ----------------------------------------
  always_comb
  begin
    o_sel_addr       = '0;                          // Slave deselected
    o_sel_addr.trans = ahb_os_pkg::HTRANS_IDLE;     // Idle when unowned
    o_sel_addr.burst = ahb_os_pkg::HBURST_SINGLE;
    o_active         = '0;

    if (!i_no_port)
    begin
      o_sel_addr            = i_port_addr[i_grant_idx];  // Whole struct
      o_active[i_grant_idx] = 1'b1;                      // Owner decode
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  // At most one port is told it owns the slave, and only with an owner
  always_comb
  begin
    a_active_onehot : assert ($onehot0(o_active) && ((o_active == '0) == i_no_port))
      else $error("active vector not one-hot or out of step with no_port");
  end

endmodule

/* ahb_os_data_phase.sv */
// Data-phase port index register and write-data mux for the shared slave
`timescale 1ns/1ps

module ahb_os_data_phase #(
  parameter  int NUM_PORTS = 4,                              // Input ports
  localparam int IDX_W     = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
  input  logic                                   HCLK,          // AHB clock
  input  logic                                   HRESETn,       // Sync reset
  input  ahb_os_pkg::ahb_wdata_t [NUM_PORTS-1:0] i_port_wdata,  // All ports
  input  logic [IDX_W-1:0]                       i_grant_idx,   // Addr owner
  input  logic                                   i_hready,      // HREADYMUXM
  output ahb_os_pkg::ahb_wdata_t                 o_hwdata       // HWDATAM
);

  // ----------------------------------------
  // Data phase index
  // ----------------------------------------
  logic [IDX_W-1:0] data_idx_q;               // Port owning the data phase

  // Address owner moves into the data phase on each completed transfer
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      data_idx_q <= '0;
    end
    else if (i_hready)
    begin
      data_idx_q <= i_grant_idx;
    end
  end

  // ----------------------------------------
  // Write data mux
  // ----------------------------------------
  assign o_hwdata = i_port_wdata[data_idx_q]; // One transfer behind address

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  // Write data source is frozen for the length of a wait state
  a_data_idx_hold : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    !i_hready |=> $stable(data_idx_q)
  );

endmodule

/* ahb_os_ready_lock.sv */
// Slave-select register, HREADYMUXM generation and locked-sequence tracking
`timescale 1ns/1ps

module ahb_os_ready_lock (
  input  logic                  HCLK,          // AHB clock
  input  logic                  HRESETn,       // Sync reset, active low
  input  ahb_os_pkg::ahb_addr_t i_sel_addr,    // Address phase to slave
  input  logic                  i_hreadyout,   // Slave HREADYOUT
  output logic                  o_hready_mux,  // HREADYMUXM
  output logic                  o_hlock_arb    // Lock as seen by arbiter
);

  // ----------------------------------------
  // HREADY generation
  // ----------------------------------------
  logic slave_sel_q;                          // Slave owns the data phase

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      slave_sel_q <= 1'b0;
    end
    else if (o_hready_mux)
    begin
      slave_sel_q <= i_sel_addr.sel;          // HSELM of the finished address phase
    end
  end

  // Slave drives the strobe only while it has a transfer in its data phase
  assign o_hready_mux = slave_sel_q ? i_hreadyout : 1'b1;

  // ----------------------------------------
  // Locked sequence tracking
  // ----------------------------------------
  logic hsel_lock_q;                          // Lock began through this slave
  logic lock_start;                           // Selected locked transfer
  logic hsel_lock_nxt;

  assign lock_start = i_sel_addr.sel && i_sel_addr.mastlock &&
                      ((i_sel_addr.trans == ahb_os_pkg::HTRANS_NONSEQ) ||
                       (i_sel_addr.trans == ahb_os_pkg::HTRANS_SEQ));

  // Stays set while the master keeps HMASTLOCK even across deselect
  assign hsel_lock_nxt = lock_start ? 1'b1 :
                         !i_sel_addr.mastlock ? 1'b0 :
                         hsel_lock_q;

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      hsel_lock_q <= 1'b0;
    end
    else if (o_hready_mux)
    begin
      hsel_lock_q <= hsel_lock_nxt;
    end
  end

  // Mastlock ignored for arbitration unless this slave is in the sequence
  assign o_hlock_arb = i_sel_addr.mastlock && (hsel_lock_q || i_sel_addr.sel);

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  a_ready_when_unsel : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    !slave_sel_q |-> o_hready_mux
  );

endmodule

/* ahb_os_top.sv */
// AHB bus-matrix output stage routing one of several input ports to one slave
`timescale 1ns/1ps

module ahb_os_top #(
  parameter  int NUM_PORTS = 4,                              // Input ports
  localparam int IDX_W     = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
  input  logic                                   HCLK,          // AHB clock
  input  logic                                   HRESETn,       // Sync reset
  input  ahb_os_pkg::ahb_addr_t  [NUM_PORTS-1:0] i_port_addr,   // Addr phases
  input  ahb_os_pkg::ahb_wdata_t [NUM_PORTS-1:0] i_port_wdata,  // Write data
  input  logic [NUM_PORTS-1:0]                   i_held_tran,   // Held tran
  input  logic                                   i_hreadyout,   // HREADYOUTM
  output logic [NUM_PORTS-1:0]                   o_active,      // Active per port
  output ahb_os_pkg::ahb_addr_t                  o_slave_addr,  // HSELM, HADDRM..
  output ahb_os_pkg::ahb_wdata_t                 o_hwdata,      // HWDATAM
  output logic                                   o_hreadymux    // HREADYMUXM
);

  // ----------------------------------------
  // Internal wiring
  // ----------------------------------------
  logic [NUM_PORTS-1:0]  req;                 // Port requests
  logic [IDX_W-1:0]      grant_idx;           // Address-phase owner
  logic                  no_port;             // No owner
  ahb_os_pkg::ahb_addr_t sel_addr;            // Selected address phase
  logic                  hready_mux;          // Transfer done strobe
  logic                  hlock_arb;           // Qualified lock

  // A port asks for the slave when selected with a held transfer
  assign req = i_held_tran & get_sel(i_port_addr);

  // ----------------------------------------
  // Control
  // ----------------------------------------
  ahb_os_arbiter #(
    .NUM_PORTS   (NUM_PORTS)
  ) u_arbiter (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .i_req       (req),
    .i_hready    (hready_mux),
    .i_trans     (sel_addr.trans),
    .i_hlock     (hlock_arb),
    .o_grant_idx (grant_idx),
    .o_no_port   (no_port)
  );

  ahb_os_ready_lock u_ready_lock (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .i_sel_addr   (sel_addr),
    .i_hreadyout  (i_hreadyout),
    .o_hready_mux (hready_mux),
    .o_hlock_arb  (hlock_arb)
  );

  // ----------------------------------------
  // Datapath
  // ----------------------------------------
  ahb_os_addr_phase #(
    .NUM_PORTS   (NUM_PORTS)
  ) u_addr_phase (
    .i_port_addr (i_port_addr),
    .i_grant_idx (grant_idx),
    .i_no_port   (no_port),
    .o_sel_addr  (sel_addr),
    .o_active    (o_active)
  );

  ahb_os_data_phase #(
    .NUM_PORTS    (NUM_PORTS)
  ) u_data_phase (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .i_port_wdata (i_port_wdata),
    .i_grant_idx  (grant_idx),
    .i_hready     (hready_mux),
    .o_hwdata     (o_hwdata)
  );

  assign o_slave_addr = sel_addr;
  assign o_hreadymux  = hready_mux;

  // Gathers the HSEL bit of every port struct
  function automatic logic [NUM_PORTS-1:0] get_sel(
    input ahb_os_pkg::ahb_addr_t [NUM_PORTS-1:0] ports
  );
    logic [NUM_PORTS-1:0] sel;

    for (int p = 0; p < NUM_PORTS; p++)
    begin
      sel[p] = ports[p].sel;
    end
    return sel;
  endfunction

endmodule

/* tb_ahb_os.sv */
// Testbench for the AHB output stage with a reference model and assertion checks
`timescale 1ns/1ps

module tb_ahb_os;

  localparam int NUM_PORTS  = 4;
  localparam int MAX_CYCLES = 2000;             // Stimulus needs about 1200

  // ----------------------------------------
  // DUT signals
  // ----------------------------------------
  logic                                   HCLK = 1'b0;
  logic                                   HRESETn;
  ahb_os_pkg::ahb_addr_t  [NUM_PORTS-1:0] port_addr;
  ahb_os_pkg::ahb_wdata_t [NUM_PORTS-1:0] port_wdata;
  logic [NUM_PORTS-1:0]                   held_tran;
  logic                                   hreadyout;
  logic [NUM_PORTS-1:0]                   active;
  ahb_os_pkg::ahb_addr_t                  slave_addr;
  ahb_os_pkg::ahb_wdata_t                 hwdata;
  logic                                   hreadymux;

  int errors = 0;                               // Failed checks
  int cycles = 0;                               // Timeout counter
  int seed   = 47;

  ahb_os_top #(
    .NUM_PORTS    (NUM_PORTS)
  ) u_dut (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .i_port_addr  (port_addr),
    .i_port_wdata (port_wdata),
    .i_held_tran  (held_tran),
    .i_hreadyout  (hreadyout),
    .o_active     (active),
    .o_slave_addr (slave_addr),
    .o_hwdata     (hwdata),
    .o_hreadymux  (hreadymux)
  );

  always #5 HCLK = ~HCLK;                       // 10 ns period

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  logic [1:0]             m_grant, m_last, m_data_idx, m_next;
  logic                   m_no_port, m_slave_sel, m_lock;
  logic                   m_hready, m_hlock, m_hold, m_found;
  logic [NUM_PORTS-1:0]   req, m_active;
  ahb_os_pkg::ahb_addr_t  m_sel_addr;
  ahb_os_pkg::ahb_wdata_t m_hwdata;

  function automatic logic [NUM_PORTS-1:0] port_bit(input logic [1:0] idx);
    logic [NUM_PORTS-1:0] v;
    v      = '0;
    v[idx] = 1'b1;
    return v;
  endfunction

  always_comb
  begin
    logic [1:0] cand;                           // Port at a given offset
    for (int i = 0; i < NUM_PORTS; i++)
    begin
      req[i[1:0]] = held_tran[i[1:0]] && port_addr[i[1:0]].sel;
    end
    m_sel_addr = m_no_port ? '0 : port_addr[m_grant];
    m_active   = m_no_port ? '0 : port_bit(m_grant);
    m_hwdata   = port_wdata[m_data_idx];       // Previous address owner
    m_hready   = m_slave_sel ? hreadyout : 1'b1;
    m_hlock    = m_sel_addr.mastlock && (m_lock || m_sel_addr.sel);
    m_hold     = !m_no_port && (m_hlock ||
                 (m_sel_addr.trans == ahb_os_pkg::HTRANS_SEQ) ||
                 (m_sel_addr.trans == ahb_os_pkg::HTRANS_BUSY));
    // Scan far to near so the nearest requester after m_last wins
    m_found = 1'b0;
    m_next  = m_last;
    for (int off = NUM_PORTS; off >= 1; off--)
    begin
      cand = m_last + off[1:0];
      if (req[cand])
      begin
        m_found = 1'b1;
        m_next  = cand;
      end
    end
  end

  always @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      m_grant     <= 2'd0;
      m_last      <= 2'd3;                      // Port 0 first
      m_no_port   <= 1'b1;
      m_data_idx  <= 2'd0;
      m_slave_sel <= 1'b0;
      m_lock      <= 1'b0;
    end
    else if (m_hready)
    begin
      m_data_idx  <= m_grant;
      m_slave_sel <= m_sel_addr.sel;
      if (m_sel_addr.sel && m_sel_addr.mastlock &&
          ((m_sel_addr.trans == ahb_os_pkg::HTRANS_NONSEQ) ||
           (m_sel_addr.trans == ahb_os_pkg::HTRANS_SEQ)))
        m_lock <= 1'b1;
      else if (!m_sel_addr.mastlock)
        m_lock <= 1'b0;                         // Lock released
      if (!m_hold)
      begin
        m_no_port <= !m_found;
        if (m_found)
        begin
          m_grant <= m_next;
          m_last  <= m_next;
        end
      end
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  task automatic report_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
    errors++;
    $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp);
  endtask

  a_reset_state : assert property (@(posedge HCLK)
    $rose(HRESETn) |-> (active == '0 && !slave_addr.sel && hreadymux))
    else report_value("{o_active,sel,o_hreadymux}",
                      64'({$sampled(active), $sampled(slave_addr.sel), $sampled(hreadymux)}),
                      64'(6'b000001));
  a_active_match : assert property (@(posedge HCLK) disable iff (!HRESETn)
    active == m_active)
    else report_value("o_active", 64'($sampled(active)), 64'($sampled(m_active)));
  a_addr_match : assert property (@(posedge HCLK) disable iff (!HRESETn)
    slave_addr == m_sel_addr)
    else report_value("o_slave_addr", 64'($sampled(slave_addr)), 64'($sampled(m_sel_addr)));
  a_hwdata_match : assert property (@(posedge HCLK) disable iff (!HRESETn)
    hwdata == m_hwdata)
    else report_value("o_hwdata", 64'($sampled(hwdata)), 64'($sampled(m_hwdata)));
  a_hready_match : assert property (@(posedge HCLK) disable iff (!HRESETn)
    hreadymux == m_hready)
    else report_value("o_hreadymux", 64'($sampled(hreadymux)), 64'($sampled(m_hready)));
  // Lone request owns the slave one clock later
  a_single_request : assert property (@(posedge HCLK) disable iff (!HRESETn)
    (m_hready && !m_hold && $onehot(req)) |=> (active == $past(req)))
    else report_value("o_active", 64'($sampled(active)), 64'($past(req)));
  a_round_robin : assert property (@(posedge HCLK) disable iff (!HRESETn)
    (m_hready && !m_hold && (&req)) |=> (active == port_bit($past(m_last) + 2'd1)))
    else report_value("o_active", 64'($sampled(active)),
                      64'(port_bit($past(m_last) + 2'd1)));
  a_hold_owner : assert property (@(posedge HCLK) disable iff (!HRESETn)
    (m_hready && m_hold) |=> $stable(active))
    else report_value("o_active", 64'($sampled(active)), 64'($past(active)));
  a_wait_freezes : assert property (@(posedge HCLK) disable iff (!HRESETn)
    !hreadymux |=> ($stable(active) && $stable(slave_addr)))
    else
    begin
      errors++;
      $display("[ERROR] %0t address phase outputs changed during a wait state", $time);
    end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  task automatic drive_port(input logic [1:0] p, input logic held, input logic sel,
                            input logic [1:0] trans, input logic lock);
    logic [31:0] r;
    r = $random(seed);
    held_tran[p]          <= held;
    port_addr[p].sel      <= sel;
    port_addr[p].addr     <= $random(seed);
    port_addr[p].trans    <= trans;
    port_addr[p].write    <= r[0];
    port_addr[p].size     <= {1'b0, r[2:1]};
    port_addr[p].burst    <= r[5:3];
    port_addr[p].prot     <= r[9:6];
    port_addr[p].mastlock <= lock;
    port_wdata[p]         <= $random(seed);
  endtask

  task automatic idle_ports();
    held_tran <= '0;
    port_addr <= '0;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge HCLK);
  endtask

  initial
  begin
    logic [31:0] r;
    HRESETn    <= 1'b0;
    hreadyout  <= 1'b1;
    held_tran  <= '0;
    port_addr  <= '0;
    port_wdata <= '0;
    wait_cycles(16);
    HRESETn <= 1'b1;
    wait_cycles(4);
    for (int k = 0; k < NUM_PORTS; k++)         // One port at a time
    begin
      drive_port(2'(k), 1'b1, 1'b1, ahb_os_pkg::HTRANS_NONSEQ, 1'b0);
      wait_cycles(6);
      idle_ports();
      wait_cycles(3);
    end
    for (int n = 0; n < 60; n++)                // All ports, single beats
    begin
      for (int k = 0; k < NUM_PORTS; k++)
        drive_port(2'(k), 1'b1, 1'b1, ahb_os_pkg::HTRANS_NONSEQ, 1'b0);
      wait_cycles(1);
    end
    idle_ports();
    wait_cycles(3);
    // Burst on port 1 against three competitors
    drive_port(2'd1, 1'b1, 1'b1, ahb_os_pkg::HTRANS_NONSEQ, 1'b0);
    wait_cycles(1);
    drive_port(2'd0, 1'b1, 1'b1, ahb_os_pkg::HTRANS_NONSEQ, 1'b0);
    drive_port(2'd2, 1'b1, 1'b1, ahb_os_pkg::HTRANS_NONSEQ, 1'b0);
    drive_port(2'd3, 1'b1, 1'b1, ahb_os_pkg::HTRANS_NONSEQ, 1'b0);
    drive_port(2'd1, 1'b1, 1'b1, ahb_os_pkg::HTRANS_SEQ, 1'b0);
    wait_cycles(4);
    drive_port(2'd1, 1'b1, 1'b1, ahb_os_pkg::HTRANS_BUSY, 1'b0);
    wait_cycles(2);
    drive_port(2'd1, 1'b1, 1'b1, ahb_os_pkg::HTRANS_SEQ, 1'b0);
    wait_cycles(2);
    drive_port(2'd1, 1'b0, 1'b0, ahb_os_pkg::HTRANS_IDLE, 1'b0);
    wait_cycles(6);
    idle_ports();
    wait_cycles(2);
    // Locked sequence on port 2 that leaves this slave for two cycles
    drive_port(2'd2, 1'b1, 1'b1, ahb_os_pkg::HTRANS_NONSEQ, 1'b1);
    wait_cycles(1);
    drive_port(2'd0, 1'b1, 1'b1, ahb_os_pkg::HTRANS_NONSEQ, 1'b0);
    drive_port(2'd3, 1'b1, 1'b1, ahb_os_pkg::HTRANS_NONSEQ, 1'b0);
    wait_cycles(1);
    drive_port(2'd2, 1'b1, 1'b0, ahb_os_pkg::HTRANS_NONSEQ, 1'b1);
    wait_cycles(2);
    drive_port(2'd2, 1'b1, 1'b1, ahb_os_pkg::HTRANS_SEQ, 1'b1);
    wait_cycles(1);
    drive_port(2'd2, 1'b1, 1'b1, ahb_os_pkg::HTRANS_NONSEQ, 1'b0);
    wait_cycles(4);
    idle_ports();
    wait_cycles(2);
    // Wait states from the slave on a port 0 transfer
    drive_port(2'd0, 1'b1, 1'b1, ahb_os_pkg::HTRANS_NONSEQ, 1'b0);
    wait_cycles(2);
    hreadyout <= 1'b0;
    wait_cycles(6);
    hreadyout <= 1'b1;
    wait_cycles(1);
    idle_ports();
    wait_cycles(2);
    for (int n = 0; n < 1000; n++)              // Random traffic
    begin
      if (m_hready)                             // Masters hold during waits
      begin
        for (int k = 0; k < NUM_PORTS; k++)
        begin
          r = $random(seed);
          drive_port(2'(k), r[0] | r[1], r[2] | r[3], r[5:4], r[9:6] == 4'd0);
        end
      end
      r = $random(seed);
      hreadyout <= (r[1:0] != 2'd0);
      wait_cycles(1);
    end
    hreadyout <= 1'b1;
    wait_cycles(4);
    $display("Run finished after %0d cycles with %0d errors", cycles, errors);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

  // ----------------------------------------
  // Timeout
  // ----------------------------------------
  always @(posedge HCLK)
  begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("=== FAIL ===");
      $finish;
    end
  end

endmodule

/* ahb_output_stage.f */
ahb_os_pkg.sv
ahb_os_arbiter.sv
ahb_os_addr_phase.sv
ahb_os_data_phase.sv
ahb_os_ready_lock.sv
ahb_os_top.sv
tb_ahb_os.sv

/* Makefile */
# Verilator flow for the AHB output stage testbench
TOP := tb_ahb_os

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) \
	  -f ahb_output_stage.f -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log
